//--- logic/rx_cfg_pkg.sv
// Receive datapath configuration constants
// Word width, delay tap select and counter sizes used by the RTL blocks
package rx_cfg_pkg;

    // **************************************************
    // Word format
    // **************************************************
    localparam int DEFAULT_WIDTH       = 10;  // Bits per deserialized word

    // **************************************************
    // Delay line and lock wait
    // **************************************************
    localparam int TAP_BITS            = 3;   // Tap select, 0 to 7 cycles
    localparam int DEFAULT_LOCK_CYCLES = 255; // Edges after reset before capture

    // **************************************************
    // Status counters
    // **************************************************
    localparam int COUNT_BITS          = 16;  // Captured word counter, wraps

endpackage

//--- logic/rx_apb_pkg.sv
// APB register map of the receive deserializer
// Addresses and field positions of control and status registers
package rx_apb_pkg;

    localparam int APB_ADDR_BITS = 4;  // Byte address, four word registers
    localparam int APB_DATA_BITS = 32; // All bus words

    // **************************************************
    // Register addresses
    // **************************************************
    localparam logic [APB_ADDR_BITS-1:0] ADDR_CTRL    = 4'h0; // Enable and tap, RW
    localparam logic [APB_ADDR_BITS-1:0] ADDR_BITSLIP = 4'h4; // Pulse on write
    localparam logic [APB_ADDR_BITS-1:0] ADDR_STATUS  = 4'h8; // Ready and count, RO
    localparam logic [APB_ADDR_BITS-1:0] ADDR_DATA    = 4'hC; // Last captured word, RO

    // **************************************************
    // Field positions
    // **************************************************
    localparam int CTRL_EN_BIT    = 0;  // Link enable
    localparam int CTRL_TAP_LSB   = 4;  // Tap field, bits 6:4
    localparam int BITSLIP_BIT    = 0;  // Write 1 to slip one bit
    localparam int STATUS_RDY_BIT = 0;  // Lock wait finished
    localparam int STATUS_CNT_LSB = 16; // Word count, bits 31:16

endpackage

//--- logic/rx_delay_line.sv
// Programmable delay of the serial input bit
// Eight-stage shift register with a tap mux and enable gating
`timescale 1ns/1ps

module rx_delay_line (
    input  logic                            clkGHz_clkbuf,
    input  logic                            reset_buf_n,
    input  logic                            enable,
    input  logic [rx_cfg_pkg::TAP_BITS-1:0] tap,
    input  logic                            serial_in,
    output logic                            delayed_bit
);

    localparam int STAGES = 1 << rx_cfg_pkg::TAP_BITS; // One stage per tap value

    logic [STAGES-1:0] stage_q; // Stage 0 is the first sample

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            stage_q <= '0;
        end else if (!enable) begin
            stage_q <= '0; // Flush, no stale bits on re-enable
        end else begin
            stage_q <= {stage_q[STAGES-2:0], serial_in};
        end
    end

    // Tap k gives k extra cycles after the input register
    assign delayed_bit = enable & stage_q[tap];

    // Flush on a disabled edge keeps the next cycle quiet for any tap
    a_quiet_after_disable : assert property (
        @(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        !$past(enable) |-> !delayed_bit
    );

endmodule

//--- logic/rx_deserializer.sv
// Serial to parallel word converter
// Shifts delayed bits in MSB first, strobes each full word, supports bitslip
`timescale 1ns/1ps

module rx_deserializer #(
    parameter int WIDTH = 10
) (
    input  logic             clkGHz_clkbuf,
    input  logic             reset_buf_n,
    input  logic             enable,
    input  logic             bitslip,
    input  logic             delayed_bit,
    output logic [WIDTH-1:0] word,
    output logic             word_valid
);

    localparam int CNT_BITS = (WIDTH > 1) ? $clog2(WIDTH) : 1;
    localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(WIDTH - 1); // Word boundary

    logic [WIDTH-1:0]    shift_q;  // Newest bit at LSB
    logic [CNT_BITS-1:0] bit_cnt;  // Position inside the current word
    logic                at_last;  // Current edge completes a word

    assign at_last = (bit_cnt == LAST_BIT);

    // **************************************************
    // Shift register
    // **************************************************
    always_ff @(posedge clkGHz_clkbuf) begin
        if (enable) begin
            shift_q <= {shift_q[WIDTH-2:0], delayed_bit}; // First bit ends as MSB
        end
    end

    assign word = shift_q; // Full word while word_valid is high

    // **************************************************
    // Bit counter and word strobe
    // **************************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt    <= '0;
            word_valid <= 1'b0;
        end else if (!enable) begin
            bit_cnt    <= '0;   // Restart alignment on next enable
            word_valid <= 1'b0;
        end else begin
            word_valid <= at_last & ~bitslip; // Slipped edge postpones strobe
            if (bitslip) begin
                bit_cnt <= bit_cnt;            // Freeze, boundary moves one bit later
            end else if (at_last) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Strobe spacing is at least one word, never back to back
    a_single_strobe : assert property (
        @(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        word_valid |=> !word_valid
    );

endmodule

//--- logic/rx_word_capture.sv
// Word capture after the lock wait
// Holds off capture for LOCK_CYCLES edges, then latches words and counts them
`timescale 1ns/1ps

module rx_word_capture #(
    parameter int WIDTH       = 10,
    parameter int LOCK_CYCLES = 255
) (
    input  logic                              clkGHz_clkbuf,
    input  logic                              reset_buf_n,
    input  logic [WIDTH-1:0]                  word,
    input  logic                              word_valid,
    output logic                              ready,
    output logic [WIDTH-1:0]                  captured_word,
    output logic [rx_cfg_pkg::COUNT_BITS-1:0] word_count
);

    localparam int LOCK_BITS = (LOCK_CYCLES > 0) ? $clog2(LOCK_CYCLES + 1) : 1;
    localparam logic [LOCK_BITS-1:0] LOCK_DONE = LOCK_BITS'(LOCK_CYCLES);

    logic [LOCK_BITS-1:0] lock_cnt; // Saturates at LOCK_DONE

    // **************************************************
    // Lock wait
    // **************************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            lock_cnt <= '0;
        end else if (lock_cnt != LOCK_DONE) begin
            lock_cnt <= lock_cnt + 1'b1;
        end
    end

    assign ready = (lock_cnt == LOCK_DONE); // High after exactly LOCK_CYCLES edges

    // **************************************************
    // Capture and count
    // **************************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            captured_word <= '0;
            word_count    <= '0;
        end else if (word_valid && ready) begin
            captured_word <= word;              // Strobes before lock are dropped
            word_count    <= word_count + 1'b1; // Wraps on overflow
        end
    end

    a_ready_sticky : assert property (
        @(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        ready |=> ready
    );

endmodule

//--- logic/rx_apb_regs.sv
// APB slave for the receive deserializer
// Control register, bitslip pulse, and status and data readback
`timescale 1ns/1ps

module rx_apb_regs #(
    parameter int WIDTH = 10
) (
    input  logic                                    clkGHz_clkbuf,
    input  logic                                    reset_buf_n,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [rx_apb_pkg::APB_ADDR_BITS-1:0]    paddr,
    input  logic [rx_apb_pkg::APB_DATA_BITS-1:0]    pwdata,
    output logic [rx_apb_pkg::APB_DATA_BITS-1:0]    prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    output logic                                    enable,
    output logic [rx_cfg_pkg::TAP_BITS-1:0]         tap,
    output logic                                    bitslip,
    input  logic                                    ready,
    input  logic [WIDTH-1:0]                        captured_word,
    input  logic [rx_cfg_pkg::COUNT_BITS-1:0]       word_count
);

    logic                                 wr_access;   // Write in access cycle
    logic                                 setup_phase; // First cycle of a transfer
    logic                                 addr_mapped; // paddr hits a register
    logic [rx_apb_pkg::APB_DATA_BITS-1:0] rdata;

    assign wr_access   = psel & penable & pwrite;
    assign setup_phase = psel & ~penable;
    assign pready      = 1'b1; // No wait states

    // **************************************************
    // Address decode and readback mux
    // **************************************************
    always_comb begin
        rdata       = '0;
        addr_mapped = 1'b1;
        case (paddr)
            rx_apb_pkg::ADDR_CTRL: begin
                rdata[rx_apb_pkg::CTRL_EN_BIT] = enable;
                rdata[rx_apb_pkg::CTRL_TAP_LSB +: rx_cfg_pkg::TAP_BITS] = tap;
            end
            rx_apb_pkg::ADDR_BITSLIP: rdata = '0; // Write only, reads zero
            rx_apb_pkg::ADDR_STATUS: begin
                rdata[rx_apb_pkg::STATUS_RDY_BIT] = ready;
                rdata[rx_apb_pkg::STATUS_CNT_LSB +: rx_cfg_pkg::COUNT_BITS] = word_count;
            end
            rx_apb_pkg::ADDR_DATA: rdata[WIDTH-1:0] = captured_word; // Zero extended
            default: addr_mapped = 1'b0;
        endcase
    end

    assign prdata = rdata;

    // **************************************************
    // Control registers and error flag
    // **************************************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            enable  <= 1'b0;
            tap     <= '0;
            bitslip <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            // One-cycle pulse after the access cycle
            bitslip <= wr_access & (paddr == rx_apb_pkg::ADDR_BITSLIP)
                       & pwdata[rx_apb_pkg::BITSLIP_BIT];
            pslverr <= setup_phase & ~addr_mapped; // Valid in the access cycle
            if (wr_access && (paddr == rx_apb_pkg::ADDR_CTRL)) begin
                enable <= pwdata[rx_apb_pkg::CTRL_EN_BIT];
                tap    <= pwdata[rx_apb_pkg::CTRL_TAP_LSB +: rx_cfg_pkg::TAP_BITS];
            end
        end
    end

    // Access cycle must follow a setup cycle of the same transfer
    a_apb_access_order : assert property (
        @(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        penable |-> psel && $past(psel)
    );

endmodule

//--- logic/serdes_rx_top.sv
// Receive deserializer top level
// Delay line, deserializer, lock-gated capture and APB control in one clock
`timescale 1ns/1ps

module serdes_rx_top #(
    parameter int WIDTH       = rx_cfg_pkg::DEFAULT_WIDTH,
    parameter int LOCK_CYCLES = rx_cfg_pkg::DEFAULT_LOCK_CYCLES
) (
    input  logic                                 clkGHz_clkbuf,
    input  logic                                 reset_buf_n,
    input  logic                                 serial_in,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [rx_apb_pkg::APB_ADDR_BITS-1:0] paddr,
    input  logic [rx_apb_pkg::APB_DATA_BITS-1:0] pwdata,
    output logic [rx_apb_pkg::APB_DATA_BITS-1:0] prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic [WIDTH-1:0]                     data_out,
    output logic                                 ready
);

    logic                              enable;      // Link enable from CTRL
    logic [rx_cfg_pkg::TAP_BITS-1:0]   tap;         // Delay select from CTRL
    logic                              bitslip;     // One-cycle slip request
    logic                              delayed_bit;
    logic [WIDTH-1:0]                  word;
    logic                              word_valid;
    logic [rx_cfg_pkg::COUNT_BITS-1:0] word_count;

    // **************************************************
    // Datapath
    // **************************************************
    rx_delay_line rx_delay_line_i (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .enable        (enable),
        .tap           (tap),
        .serial_in     (serial_in),
        .delayed_bit   (delayed_bit)
    );

    rx_deserializer #(.WIDTH(WIDTH)) rx_deserializer_i (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .enable        (enable),
        .bitslip       (bitslip),
        .delayed_bit   (delayed_bit),
        .word          (word),
        .word_valid    (word_valid)
    );

    rx_word_capture #(.WIDTH(WIDTH), .LOCK_CYCLES(LOCK_CYCLES)) rx_word_capture_i (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .word          (word),
        .word_valid    (word_valid),
        .ready         (ready),
        .captured_word (data_out),   // Captured word goes straight out
        .word_count    (word_count)
    );

    // **************************************************
    // Register interface
    // **************************************************
    rx_apb_regs #(.WIDTH(WIDTH)) rx_apb_regs_i (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .enable        (enable),
        .tap           (tap),
        .bitslip       (bitslip),
        .ready         (ready),
        .captured_word (data_out),
        .word_count    (word_count)
    );

endmodule

//--- sim/tb_clock_gen.sv
// Testbench clock and reset source
// 40 ns clock, reset held low over the first eight rising edges
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clkGHz_clkbuf,
    output logic reset_buf_n
);

    initial begin
        clkGHz_clkbuf = 1'b0;
        forever #(PERIOD_NS / 2) clkGHz_clkbuf = ~clkGHz_clkbuf; // First rise at half period
    end

    initial begin
        reset_buf_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clkGHz_clkbuf);
        @(negedge clkGHz_clkbuf);
        reset_buf_n = 1'b1; // Release away from the rising edge
    end

endmodule

//--- sim/tb_serdes_rx.sv
// Testbench for the receive deserializer
// LFSR serial stream, APB control, reference word model and per-test report
`timescale 1ns/1ps

module tb_serdes_rx;

    localparam int WIDTH          = 10;   // Word width of the DUT
    localparam int LOCK_CYCLES    = 255;  // Lock wait of the DUT
    localparam int RESET_CYCLES   = 8;
    localparam int RUN_WORDS      = 24;   // Words per enabled run
    localparam int RUN_CYCLES     = RUN_WORDS * WIDTH + 40; // Words plus APB overhead
    localparam int TEST_CYCLES    = RESET_CYCLES + LOCK_CYCLES + 6 * RUN_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                                 clkGHz_clkbuf;
    logic                                 reset_buf_n;
    logic                                 serial_in = 1'b0;
    logic                                 psel;
    logic                                 penable;
    logic                                 pwrite;
    logic [rx_apb_pkg::APB_ADDR_BITS-1:0] paddr;
    logic [31:0]                          pwdata;
    logic [31:0]                          prdata;
    logic                                 pready;
    logic                                 pslverr;
    logic [WIDTH-1:0]                     data_out;
    logic                                 ready;

    int               edge_cnt = 0;        // Rising edges since time zero
    logic             sample_q [$];        // Serial bit per sampling edge
    int               slip_q [$];          // Edges where the bit counter freezes
    int               en_edge = 0;         // Access edge of the enabling write
    int               dis_edge = 0;        // Access edge of the disabling write
    int               ses_tap = 0;         // Tap of the current run
    logic             tb_enable = 1'b0;    // Enable as last written
    logic [31:0]      lfsr = 32'h123e;
    logic [WIDTH-1:0] last_data = '0;      // Last word the model expects captured
    logic [WIDTH-1:0] exp_word;
    int               exp_words = 0;       // Captures the model expects
    int               errors = 0;
    int               test_err0 = 0;
    string            cur_test = "reset";

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n)
    );

    serdes_rx_top #(.WIDTH(WIDTH), .LOCK_CYCLES(LOCK_CYCLES)) serdes_rx_top_i (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .serial_in     (serial_in),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .data_out      (data_out),
        .ready         (ready)
    );

    // **************************************************
    // Reference model
    // **************************************************
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
    endfunction

    // Bit entering the deserializer at edge m of the current run
    function automatic logic deser_bit(input int m);
        int src;
        src = m - 1 - ses_tap;                 // Input register plus tap stages
        if (src > en_edge) return sample_q[src];
        return 1'b0;                           // Delay line flushed before the run
    endfunction

    function automatic logic is_slip_edge(input int m);
        foreach (slip_q[i]) begin
            if (slip_q[i] == m) return 1'b1;
        end
        return 1'b0;
    endfunction

    // True if edge m completes a word, counting from the enable edge
    function automatic logic word_ends_at(input int m);
        int   cnt;
        int   k;
        logic ends;
        cnt  = 0;
        ends = 1'b0;
        if (m <= en_edge || m > dis_edge) return 1'b0;
        for (k = en_edge + 1; k <= m; k++) begin
            ends = 1'b0;
            if (!is_slip_edge(k)) begin        // Slip edge holds the count
                if (cnt == WIDTH - 1) begin
                    ends = 1'b1;
                    cnt  = 0;
                end else begin
                    cnt++;
                end
            end
        end
        return ends;
    endfunction

    function automatic logic [WIDTH-1:0] ref_word(input int end_edge);
        logic [WIDTH-1:0] w;
        int               k;
        w = '0;
        for (k = end_edge - WIDTH + 1; k <= end_edge; k++) begin
            w = {w[WIDTH-2:0], deser_bit(k)}; // First bit ends as MSB
        end
        return w;
    endfunction

    // **************************************************
    // Reporting and APB tasks
    // **************************************************
    task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        errors++;
        $display("Fail %s %s expected 0x%h actual 0x%h", cur_test, what, exp_v, act_v);
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        $display("%s: finished with %0d errors", cur_test, errors - test_err0);
    endtask

    // Setup then access; returns at the falling edge after the access edge
    task automatic apb_xfer(input logic wr, input logic [rx_apb_pkg::APB_ADDR_BITS-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        @(negedge clkGHz_clkbuf);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clkGHz_clkbuf);
        penable = 1'b1;
        if (pready !== 1'b1) report_mismatch("pready", 32'h1, 32'(pready)); // No wait states
        while (!pready) @(negedge clkGHz_clkbuf);
        rdata = prdata;
        err   = pslverr;
        @(negedge clkGHz_clkbuf);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic set_ctrl(input logic en, input logic [rx_cfg_pkg::TAP_BITS-1:0] tap);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, rx_apb_pkg::ADDR_CTRL, {25'b0, tap, 3'b0, en}, rd, err);
        if (en && !tb_enable) begin            // New run starts after this edge
            en_edge  = edge_cnt;
            dis_edge = TIMEOUT_CYCLES + 16;
            ses_tap  = int'(tap);
        end else if (!en && tb_enable) begin
            dis_edge = edge_cnt;               // Last shifting edge
        end
        tb_enable = en;
    endtask

    task automatic bitslip_once();
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, rx_apb_pkg::ADDR_BITSLIP, 32'h1, rd, err);
        slip_q.push_back(edge_cnt + 1);        // Pulse acts on the next edge
    endtask

    task automatic wait_words(input int n);
        int target;
        target = exp_words + n;
        while (exp_words < target) @(negedge clkGHz_clkbuf);
    endtask

    task automatic check_counters();
        logic [31:0] rd;
        logic        err;
        repeat (3) @(negedge clkGHz_clkbuf);   // Let a final strobe land
        apb_xfer(1'b0, rx_apb_pkg::ADDR_STATUS, 32'h0, rd, err);
        if (rd[31:16] !== 16'(exp_words))
            report_mismatch("word count", 32'(exp_words), {16'h0, rd[31:16]});
        apb_xfer(1'b0, rx_apb_pkg::ADDR_DATA, 32'h0, rd, err);
        if (rd !== 32'(last_data)) report_mismatch("DATA", 32'(last_data), rd);
    endtask

    task automatic run_words(input logic [rx_cfg_pkg::TAP_BITS-1:0] tap, input int n);
        set_ctrl(1'b1, tap);
        wait_words(n);
        set_ctrl(1'b0, tap);
        check_counters();
    endtask

    // **************************************************
    // Free-running processes
    // **************************************************
    always @(posedge clkGHz_clkbuf) edge_cnt <= edge_cnt + 1;

    always @(posedge clkGHz_clkbuf) begin
        if (edge_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", edge_cnt);
            $display("test failed");
            $finish;
        end
    end

    always @(negedge clkGHz_clkbuf) begin
        if (edge_cnt > 0) begin                // Ignore the start-up clock transition
            lfsr = lfsr_step(lfsr);            // One step per serial bit
            serial_in = lfsr[0];
            sample_q.push_back(lfsr[0]);       // Sampled at the next rising edge
        end
    end

    // Comparison against the reference, one edge after each expected strobe
    always @(negedge clkGHz_clkbuf) begin
        if (reset_buf_n) begin
            if (word_ends_at(edge_cnt - 1)) begin
                exp_word  = ref_word(edge_cnt - 1);
                exp_words++;
                if (data_out !== exp_word) report_mismatch("word", 32'(exp_word), 32'(data_out));
                last_data = exp_word;
            end else if (data_out !== last_data) begin
                report_mismatch("data_out hold", 32'(last_data), 32'(data_out));
                last_data = data_out;          // Report each stray change once
            end
        end
    end

    // **************************************************
    // Test sequence
    // **************************************************
    initial begin : main_seq
        logic [31:0] rd;
        logic        err;
        int          rel_edge;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        sample_q.push_back(1'b0);              // Edges 0 and 1 see the idle input
        sample_q.push_back(1'b0);

        start_test("reset_lock");
        @(posedge reset_buf_n);
        rel_edge = edge_cnt;
        apb_xfer(1'b0, rx_apb_pkg::ADDR_STATUS, 32'h0, rd, err);
        if (ready !== 1'b0) report_mismatch("ready port", 32'h0, 32'(ready));
        if (rd[0] !== 1'b0) report_mismatch("STATUS ready", 32'h0, 32'(rd[0]));
        while (!ready) @(negedge clkGHz_clkbuf);
        if (edge_cnt !== rel_edge + LOCK_CYCLES)
            report_mismatch("ready edge", rel_edge + LOCK_CYCLES, edge_cnt);
        apb_xfer(1'b0, rx_apb_pkg::ADDR_STATUS, 32'h0, rd, err);
        if (rd !== 32'h1) report_mismatch("STATUS after lock", 32'h1, rd);
        end_test();

        start_test("deserialize_tap0");
        run_words(3'd0, RUN_WORDS);
        end_test();

        start_test("delay_tap");
        run_words(3'd3, RUN_WORDS);
        run_words(3'd7, RUN_WORDS);
        end_test();

        start_test("bitslip");
        set_ctrl(1'b1, 3'd0);
        wait_words(4);
        bitslip_once();
        wait_words(6);
        bitslip_once();                        // Second slip, boundary two bits later
        wait_words(RUN_WORDS / 2);
        set_ctrl(1'b0, 3'd0);
        check_counters();
        end_test();

        start_test("disable");
        run_words(3'd1, 3);
        repeat (4 * WIDTH) @(negedge clkGHz_clkbuf); // Bits keep arriving
        check_counters();
        end_test();

        start_test("apb_access");
        set_ctrl(1'b0, 3'd5);
        apb_xfer(1'b0, rx_apb_pkg::ADDR_CTRL, 32'h0, rd, err);
        if (rd !== 32'h50) report_mismatch("CTRL readback", 32'h50, rd);
        if (err !== 1'b0) report_mismatch("pslverr mapped", 32'h0, 32'(err));
        apb_xfer(1'b0, 4'h2, 32'h0, rd, err);
        if (err !== 1'b1) report_mismatch("pslverr unmapped read", 32'h1, 32'(err));
        apb_xfer(1'b1, 4'hE, 32'hFFFF_FFFF, rd, err);
        if (err !== 1'b1) report_mismatch("pslverr unmapped write", 32'h1, 32'(err));
        end_test();

        $display("summary: 6 tests, %0d words compared, %0d errors", exp_words, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- files.f
logic/rx_cfg_pkg.sv
logic/rx_apb_pkg.sv
logic/rx_delay_line.sv
logic/rx_deserializer.sv
logic/rx_word_capture.sv
logic/rx_apb_regs.sv
logic/serdes_rx_top.sv
sim/tb_clock_gen.sv
sim/tb_serdes_rx.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the receive deserializer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/tb_serdes_rx

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_serdes_rx -Mdir obj_dir -o tb_serdes_rx -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^test passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
